// ==== src/aui_am_pkg.sv ====
`default_nettype none

package aui_am_pkg;

    // Symbol and marker geometry
    localparam int SYM_W = 10;
    localparam int AM_W = 120;
    localparam int NUM_LANES = 16;

    // Flow geometry
    localparam int BLOCK_W = 257;
    localparam int BLOCKS_PER_FLOW = 40;
    localparam int FLOW_W = BLOCK_W * BLOCKS_PER_FLOW;
    localparam int HDR_W = 1028;

    // Codeword geometry
    localparam int CW_SYMS = 544;
    localparam int PARITY_SYMS = 30;
    localparam int MSG_SYMS = CW_SYMS - PARITY_SYMS;
    localparam int CW_W = CW_SYMS * SYM_W;

    // One group is one symbol from each of the four codewords
    localparam int NUM_CW = 4;
    localparam int GROUP_W = NUM_CW * SYM_W;
    localparam int GROUPS_PER_LANE = CW_SYMS / NUM_LANES;
    localparam int LANE_W = GROUPS_PER_LANE * GROUP_W;

    typedef logic [AM_W-1:0] am_word_t;
    typedef logic [LANE_W-1:0] lane_word_t;

    typedef struct packed {
        logic [HDR_W-1:0] f1;
        logic [HDR_W-1:0] f0;
    } flow_hdr_t;

    typedef struct packed {
        logic [CW_W-1:0] d;
        logic [CW_W-1:0] c;
        logic [CW_W-1:0] b;
        logic [CW_W-1:0] a;
    } codeword_set_t;

    typedef struct packed {
        lane_word_t [NUM_LANES-1:0] lane;
    } lane_bus_t;

    // Per-lane alignment markers, as transmitted before byte reversal
    localparam am_word_t AM_TABLE [NUM_LANES] = '{
        120'h9a4a26b665b5d9d9fe8e0c260171f3,
        120'h9a4a260465b5d967a52181985ade7e,
        120'h9a4a264665b5d9fec10ca9013ef356,
        120'h9a4a265a65b5d984797f2f7b8680d0,
        120'h9a4a26e165b5d919d5ae0de62a51f2,
        120'h9a4a26f265b5d94eedb02eb1124fd1,
        120'h9a4a263d65b5d9eebd635e11429ca1,
        120'h9a4a262265b5d9322989a4cdd6765b,
        120'h9a4a266065b5d99f1e8c8a60e17375,
        120'h9a4a266b65b5d9a28e3bc35d71c43c,
        120'h9a4a26fa65b5d9046a1427fb95ebd8,
        120'h9a4a266c65b5d971dd99c78e226638,
        120'h9a4a261865b5d95b5d096aa4a2f695,
        120'h9a4a261465b5d9ccce683c333197c3,
        120'h9a4a26d065b5d9b13504594ecafba6,
        120'h9a4a26b465b5d956594586a9a6ba79
    };

    // Data fill above each header
    localparam logic [7:0] FILL_F0 = 8'h30;
    localparam logic [7:0] FILL_F1 = 8'h06;

    // Header pad and flow 1 status
    localparam logic [3:0] PAD_NIBBLE = 4'h6;
    localparam logic [2:0] STATUS_F1 = 3'b111;

    // Stand-in for RS parity, one nibble per codeword
    localparam logic [3:0] PARITY_NIBBLE_A = 4'd1;
    localparam logic [3:0] PARITY_NIBBLE_B = 4'd2;
    localparam logic [3:0] PARITY_NIBBLE_C = 4'd3;
    localparam logic [3:0] PARITY_NIBBLE_D = 4'd4;

endpackage

`default_nettype wire

// ==== src/am_mapper.sv ====
`default_nettype none

module am_mapper (
    output aui_am_pkg::flow_hdr_t o_hdr
);
    import aui_am_pkg::*;

    localparam int AM_BYTES = AM_W / 8;
    localparam int SLOT_W = 2 * SYM_W;
    localparam int SLOT_GROUPS = AM_W / (2 * SLOT_W);
    localparam int GROUP_SPAN = NUM_LANES * SLOT_W;
    localparam int PAD_LO = SLOT_GROUPS * GROUP_SPAN;
    localparam int PAD_F0_W = HDR_W - PAD_LO;
    localparam int PAD_F1_W = PAD_F0_W - 3;
    localparam int PAD_NIBBLES = PAD_F0_W / 4;

    am_word_t am_rev [NUM_LANES];
    flow_hdr_t hdr;

    // Byte j goes to byte 14-j, bits inside a byte stay put
    function automatic am_word_t reverse_bytes(input am_word_t w);
        am_word_t r;
        r = '0;
        for (int b = 0; b < AM_BYTES; b++) begin
            r[(AM_BYTES - 1 - b) * 8 +: 8] = w[b * 8 +: 8];
        end
        return r;
    endfunction

    always_comb begin
        for (int j = 0; j < NUM_LANES; j++) begin
            am_rev[j] = reverse_bytes(AM_TABLE[j]);
        end
    end

    always_comb begin
        hdr = '0;

        // f0 takes the low 20 bits of each 40-bit chunk, f1 the high 20
        for (int k = 0; k < SLOT_GROUPS; k++) begin
            for (int j = 0; j < NUM_LANES; j++) begin
                hdr.f0[GROUP_SPAN * k + SLOT_W * j +: SLOT_W] =
                    am_rev[j][2 * SLOT_W * k +: SLOT_W];
                hdr.f1[GROUP_SPAN * k + SLOT_W * j +: SLOT_W] =
                    am_rev[j][2 * SLOT_W * k + SLOT_W +: SLOT_W];
            end
        end

        hdr.f0[HDR_W-1:PAD_LO] = {PAD_NIBBLES{PAD_NIBBLE}};

        // Top pad bit of flow 1 stays zero under the status field
        hdr.f1[PAD_LO + PAD_F1_W - 1:PAD_LO] = {1'b0, {(PAD_NIBBLES - 1){PAD_NIBBLE}}};
        hdr.f1[HDR_W-1:HDR_W-3] = STATUS_F1;
    end

    assign o_hdr = hdr;

endmodule

`default_nettype wire

// ==== src/codeword_builder.sv ====
`default_nettype none

module codeword_builder (
    input  wire aui_am_pkg::flow_hdr_t i_hdr,
    output aui_am_pkg::codeword_set_t  o_cw
);
    import aui_am_pkg::*;

    localparam int FILL_W = FLOW_W - HDR_W;
    localparam int FILL_BYTES = (FILL_W + 7) / 8;
    localparam int PAIR_W = 2 * SYM_W;
    localparam int PARITY_W = PARITY_SYMS * SYM_W;
    localparam int PARITY_NIBBLES = PARITY_W / 4;

    logic [FLOW_W-1:0] flow_f0;
    logic [FLOW_W-1:0] flow_f1;
    codeword_set_t cw;

    // Header in the low bits, fill byte repeated up to the flow width
    function automatic logic [FLOW_W-1:0] fill_flow(
        input logic [HDR_W-1:0] hdr,
        input logic [7:0]       fill_byte
    );
        logic [FILL_BYTES*8-1:0] fill;
        fill = {FILL_BYTES{fill_byte}};
        return {fill[FILL_W-1:0], hdr};
    endfunction

    assign flow_f0 = fill_flow(i_hdr.f0, FILL_F0);
    assign flow_f1 = fill_flow(i_hdr.f1, FILL_F1);

    always_comb begin
        // Symbol l sits at the MSB end of the codeword, pair l of the flow
        for (int l = 0; l < MSG_SYMS; l++) begin
            cw.a[(CW_SYMS - l) * SYM_W - 1 -: SYM_W] = flow_f0[PAIR_W * l +: SYM_W];
            cw.b[(CW_SYMS - l) * SYM_W - 1 -: SYM_W] = flow_f0[PAIR_W * l + SYM_W +: SYM_W];
            cw.c[(CW_SYMS - l) * SYM_W - 1 -: SYM_W] = flow_f1[PAIR_W * l +: SYM_W];
            cw.d[(CW_SYMS - l) * SYM_W - 1 -: SYM_W] = flow_f1[PAIR_W * l + SYM_W +: SYM_W];
        end

        // Parity tail
        cw.a[PARITY_W-1:0] = {PARITY_NIBBLES{PARITY_NIBBLE_A}};
        cw.b[PARITY_W-1:0] = {PARITY_NIBBLES{PARITY_NIBBLE_B}};
        cw.c[PARITY_W-1:0] = {PARITY_NIBBLES{PARITY_NIBBLE_C}};
        cw.d[PARITY_W-1:0] = {PARITY_NIBBLES{PARITY_NIBBLE_D}};
    end

    assign o_cw = cw;

endmodule

`default_nettype wire

// ==== src/lane_distributor.sv ====
`default_nettype none

module lane_distributor (
    input  wire aui_am_pkg::codeword_set_t i_cw,
    output aui_am_pkg::lane_bus_t          o_frame
);
    import aui_am_pkg::*;

    lane_bus_t frame;

    // Symbol idx of a codeword, counted from the MSB end
    function automatic logic [SYM_W-1:0] sym_at(
        input logic [CW_W-1:0] cw,
        input int              idx
    );
        return cw[(CW_SYMS - idx) * SYM_W - 1 -: SYM_W];
    endfunction

    always_comb begin
        // Round-robin, symbol 16k+n lands in lane n, group k
        for (int n = 0; n < NUM_LANES; n++) begin
            for (int k = 0; k < GROUPS_PER_LANE; k++) begin
                frame.lane[n][GROUP_W * k +: SYM_W] =
                    sym_at(i_cw.a, NUM_LANES * k + n);
                frame.lane[n][GROUP_W * k + SYM_W +: SYM_W] =
                    sym_at(i_cw.b, NUM_LANES * k + n);
                frame.lane[n][GROUP_W * k + 2 * SYM_W +: SYM_W] =
                    sym_at(i_cw.c, NUM_LANES * k + n);
                frame.lane[n][GROUP_W * k + 3 * SYM_W +: SYM_W] =
                    sym_at(i_cw.d, NUM_LANES * k + n);
            end
        end
    end

    assign o_frame = frame;

endmodule

`default_nettype wire

// ==== src/block_scheduler.sv ====
`default_nettype none

module block_scheduler #(
    parameter int BLOCKS_REPETITION = 8192
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire aui_am_pkg::lane_bus_t i_frame,
    output aui_am_pkg::lane_bus_t      o_lanes,
    output logic                       o_sync
);

    localparam int CNT_W = (BLOCKS_REPETITION > 1) ? $clog2(BLOCKS_REPETITION) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCKS_REPETITION - 1);

    logic [CNT_W-1:0] blk_cnt;
    logic             frame_slot;

    // Free-running block counter, wraps after BLOCKS_REPETITION
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_cnt <= '0;
        end else if (blk_cnt == CNT_LAST) begin
            blk_cnt <= '0;
        end else begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    assign frame_slot = (blk_cnt == '0);

    // Marker frame on count zero, idle ones otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            o_lanes <= '1;
            o_sync  <= 1'b0;
        end else if (frame_slot) begin
            o_lanes <= i_frame;
            o_sync  <= 1'b1;
        end else begin
            o_lanes <= '1;
            o_sync  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/aui_am_tx.sv ====
`default_nettype none

module aui_am_tx #(
    parameter int BLOCKS_REPETITION = 8192
) (
    input  wire                   clk,
    input  wire                   rst,
    output aui_am_pkg::lane_bus_t o_lanes,
    output logic                  o_sync
);
    import aui_am_pkg::*;

    flow_hdr_t     hdr;
    codeword_set_t cw;
    lane_bus_t     frame;

    // Constant marker frame, built combinationally
    am_mapper u_am_mapper (
        .o_hdr (hdr)
    );

    codeword_builder u_codeword_builder (
        .i_hdr (hdr),
        .o_cw  (cw)
    );

    lane_distributor u_lane_distributor (
        .i_cw    (cw),
        .o_frame (frame)
    );

    // Periodic insertion onto the lanes
    block_scheduler #(
        .BLOCKS_REPETITION (BLOCKS_REPETITION)
    ) u_block_scheduler (
        .clk     (clk),
        .rst     (rst),
        .i_frame (frame),
        .o_lanes (o_lanes),
        .o_sync  (o_sync)
    );

endmodule

`default_nettype wire

// ==== sim/tb_lane_model.svh ====
`ifndef TB_LANE_MODEL_SVH
`define TB_LANE_MODEL_SVH

// Header layout, three groups of sixteen 20-bit slots below the pad
localparam int SLOT_BITS = 2 * SYM_W;
localparam int SLOT_GROUP_BITS = NUM_LANES * SLOT_BITS;
localparam int PAD_START = 3 * SLOT_GROUP_BITS;
localparam int STATUS_START = HDR_W - 3;

// Bit p of marker j once its bytes are reversed
function automatic logic reversed_marker_bit(input int j, input int p);
    int src_byte;
    src_byte = AM_W / 8 - 1 - p / 8;
    return AM_TABLE[j][src_byte * 8 + p % 8];
endfunction

function automatic logic header_bit(input int f, input int b);
    int k;
    int j;
    int off;
    if (b < PAD_START) begin
        k = b / SLOT_GROUP_BITS;
        j = (b % SLOT_GROUP_BITS) / SLOT_BITS;
        off = b % SLOT_BITS;
        // Flow 1 takes the upper half of each 40-bit marker chunk
        return reversed_marker_bit(j, 2 * SLOT_BITS * k + SLOT_BITS * f + off);
    end
    if (f == 1 && b >= STATUS_START) begin
        return STATUS_F1[b - STATUS_START];
    end
    if (f == 1 && b == STATUS_START - 1) begin
        return 1'b0;
    end
    return PAD_NIBBLE[(b - PAD_START) % 4];
endfunction

function automatic logic flow_bit(input int f, input int b);
    logic [7:0] fill;
    fill = (f == 0) ? FILL_F0 : FILL_F1;
    if (b < HDR_W) begin
        return header_bit(f, b);
    end
    return fill[(b - HDR_W) % 8];
endfunction

function automatic logic [3:0] parity_nibble(input int x);
    case (x)
        0: return PARITY_NIBBLE_A;
        1: return PARITY_NIBBLE_B;
        2: return PARITY_NIBBLE_C;
        default: return PARITY_NIBBLE_D;
    endcase
endfunction

// Symbol s of codeword x (0 to 3 for a to d), counted from the MSB end
function automatic logic [SYM_W-1:0] codeword_symbol(input int x, input int s);
    logic [SYM_W-1:0] sym;
    logic [3:0] nib;
    int pos;
    nib = parity_nibble(x);
    for (int t = 0; t < SYM_W; t++) begin
        if (s >= MSG_SYMS) begin
            // Bit position inside the codeword, from its LSB
            pos = (CW_SYMS - 1 - s) * SYM_W + t;
            sym[t] = nib[pos % 4];
        end else begin
            sym[t] = flow_bit(x / 2, 2 * SYM_W * s + SYM_W * (x % 2) + t);
        end
    end
    return sym;
endfunction

function automatic lane_word_t expected_lane(input int n);
    lane_word_t w;
    w = '0;
    for (int k = 0; k < GROUPS_PER_LANE; k++) begin
        for (int x = 0; x < 4; x++) begin
            w[4 * SYM_W * k + SYM_W * x +: SYM_W] = codeword_symbol(x, NUM_LANES * k + n);
        end
    end
    return w;
endfunction

`endif

// ==== sim/tb_aui_am_tx.sv ====
`default_nettype none

module tb_aui_am_tx;
    timeunit 1ns;
    timeprecision 100ps;

    import aui_am_pkg::*;

    `include "tb_lane_model.svh"

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int REPETITION = 16;
    localparam int NUM_PULSES = 8;
    localparam int REPEAT_PULSE = 4;
    localparam int SYNC_WAIT = 2 * REPETITION;
    localparam int PERIOD_WAIT = NUM_PULSES * REPETITION + 4;
    localparam int TEST_CYCLES = RESET_CYCLES + SYNC_WAIT + PERIOD_WAIT;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic      clk;
    logic      rst;
    lane_bus_t lanes;
    logic      sync;

    lane_word_t exp_lanes [NUM_LANES];
    lane_word_t fourth_frame [NUM_LANES];
    int error_count;
    int tests_run;
    int tests_failed;
    int cycle = 0;
    int last_sync_cycle;

    aui_am_tx #(
        .BLOCKS_REPETITION (REPETITION)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .o_lanes (lanes),
        .o_sync  (sync)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic compare_value(input string test_name, input string item,
                                 input lane_word_t expected, input lane_word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, item, expected, actual);
        end
    endtask

    task automatic finish_test(input string test_name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, error_count - errs_before);
        end
    endtask

    task automatic check_idle(input string test_name);
        compare_value(test_name, "o_sync", '0, lane_word_t'(sync));
        for (int n = 0; n < NUM_LANES; n++) begin
            compare_value(test_name, $sformatf("lane %0d idle", n), '1, lanes.lane[n]);
        end
    endtask

    // Symbols 514 to 543 sit in groups 32 and 33
    task automatic check_parity_tail(input string test_name);
        int s;
        for (int k = GROUPS_PER_LANE - 2; k < GROUPS_PER_LANE; k++) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                s = NUM_LANES * k + n;
                if (s >= MSG_SYMS) begin
                    for (int x = 0; x < 4; x++) begin
                        compare_value(test_name,
                            $sformatf("lane %0d group %0d cw %0d parity", n, k, x),
                            lane_word_t'(codeword_symbol(x, s)),
                            lane_word_t'(lanes.lane[n][4 * SYM_W * k + SYM_W * x +: SYM_W]));
                    end
                end
            end
        end
    endtask

    task automatic test_reset_idle();
        int errs_before;
        errs_before = error_count;
        for (int i = 1; i <= RESET_CYCLES; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (i == RESET_CYCLES) begin
                rst = 1'b0;
            end
            @(negedge clk);
            check_idle("reset_idle");
        end
        finish_test("reset_idle", errs_before);
    endtask

    task automatic test_first_frame();
        int errs_before;
        int waited;
        errs_before = error_count;
        waited = 0;
        while (waited < SYNC_WAIT && sync !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        if (sync !== 1'b1) begin
            error_count++;
            $display("first_frame: no sync pulse within %0d cycles of reset release", SYNC_WAIT);
        end else begin
            compare_value("first_frame", "cycles to sync", lane_word_t'(1), lane_word_t'(waited));
            for (int n = 0; n < NUM_LANES; n++) begin
                compare_value("first_frame", $sformatf("lane %0d", n), exp_lanes[n],
                              lanes.lane[n]);
            end
            check_parity_tail("first_frame");
            last_sync_cycle = cycle;
        end
        finish_test("first_frame", errs_before);
    endtask

    task automatic test_sync_period();
        int   errs_before;
        int   pulses;
        int   waited;
        logic prev_sync;
        errs_before = error_count;
        pulses = 1;
        waited = 0;
        prev_sync = 1'b1;
        while (pulses < NUM_PULSES && waited < PERIOD_WAIT) begin
            @(negedge clk);
            waited++;
            if (sync === 1'b1) begin
                if (prev_sync) begin
                    error_count++;
                    $display("sync_period: o_sync high for more than one cycle at cycle %0d",
                             cycle);
                end
                pulses++;
                compare_value("sync_period", $sformatf("pulse %0d spacing", pulses),
                              lane_word_t'(REPETITION), lane_word_t'(cycle - last_sync_cycle));
                last_sync_cycle = cycle;
                if (pulses == REPEAT_PULSE) begin
                    for (int n = 0; n < NUM_LANES; n++) begin
                        fourth_frame[n] = lanes.lane[n];
                    end
                end
            end else begin
                check_idle("sync_period");
            end
            prev_sync = sync;
        end
        if (pulses < NUM_PULSES) begin
            error_count++;
            $display("sync_period: only %0d of %0d sync pulses seen", pulses, NUM_PULSES);
        end
        finish_test("sync_period", errs_before);
    endtask

    task automatic test_frame_repeat();
        int errs_before;
        errs_before = error_count;
        for (int n = 0; n < NUM_LANES; n++) begin
            compare_value("frame_repeat", $sformatf("lane %0d", n), exp_lanes[n],
                          fourth_frame[n]);
        end
        finish_test("frame_repeat", errs_before);
    endtask

    initial begin
        rst = 1'b1;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        last_sync_cycle = 0;
        for (int n = 0; n < NUM_LANES; n++) begin
            exp_lanes[n] = expected_lane(n);
        end

        test_reset_idle();
        test_first_frame();
        test_sync_period();
        test_frame_repeat();

        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aui_am_tx.f ====
+incdir+sim
src/aui_am_pkg.sv
src/am_mapper.sv
src/codeword_builder.sv
src/lane_distributor.sv
src/block_scheduler.sv
src/aui_am_tx.sv
sim/tb_aui_am_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f aui_am_tx.f --top-module tb_aui_am_tx -o tb_aui_am_tx

out=$(./obj_dir/tb_aui_am_tx)
echo "$out"

if echo "$out" | grep -F -x -q '>>> PASS'; then
    exit 0
else
    exit 1
fi
